// File: source/sig_gen_pkg.sv
/*
 * signal generator shared definitions
 * channel count, data path widths, register map, control word views
 * and the saturation helper used by the channels and the mixer
 */
package sig_gen_pkg;

  ////////////////////
  // data path
  ////////////////////

  // channel count
  localparam int NCH = 2;
  // signed sample width
  localparam int DW = 14;
  // table address width, 256 entries
  localparam int TAW = 8;
  // pointer fixed point, integer part is the table index
  localparam int CWF = 16;
  localparam int CW = TAW + CWF;
  // burst period count
  localparam int BNW = 16;
  // gain, 1.0 = 2^MSH
  localparam int MW = 16;
  localparam int MSH = 13;
  // product width
  localparam int PW = DW + MW;
  // mixer accumulator width
  localparam int XW = DW + $clog2(NCH);
  // signed sample range
  localparam int SMAX = 2**(DW-1) - 1;
  localparam int SMIN = -(2**(DW-1));

  ////////////////////
  // bus and register map
  ////////////////////

  localparam int AW = 12;
  localparam int BW = 32;
  // address bit selecting the channel, then table vs registers
  localparam int ADR_CH = 11;
  localparam int ADR_TBL = 10;
  // offsets within a channel register window
  localparam logic [ADR_TBL-1:0] REG_CTL = 10'h000;
  localparam logic [ADR_TBL-1:0] REG_MODE = 10'h004;
  localparam logic [ADR_TBL-1:0] REG_SIZ = 10'h008;
  localparam logic [ADR_TBL-1:0] REG_OFF = 10'h00c;
  localparam logic [ADR_TBL-1:0] REG_STE = 10'h010;
  localparam logic [ADR_TBL-1:0] REG_BNM = 10'h014;
  localparam logic [ADR_TBL-1:0] REG_MUL = 10'h018;
  localparam logic [ADR_TBL-1:0] REG_SUM = 10'h01c;
  localparam logic [ADR_TBL-1:0] REG_IRQ = 10'h020;
  // bit positions in the mode and interrupt registers
  localparam int MODE_BEN = 0;
  localparam int MODE_INF = 1;
  localparam int MODE_ENA = 2;
  localparam int IRQ_ENA = 0;
  localparam int IRQ_STS = 1;

  // control word as written, command bits
  typedef struct packed {
    logic [26:0] rsv;
    logic trg_ena;
    logic swt;
    logic stp;
    logic str;
    logic rst;
  } ctl_cmd_t;

  // control word as read, status bits
  // trg_ena sits at the same position as in the command view
  typedef struct packed {
    logic [26:0] rsv;
    logic trg_ena;
    logic [1:0] rsv_lo;
    logic last;
    logic running;
  } ctl_sts_t;

  typedef union packed {
    ctl_cmd_t cmd;
    ctl_sts_t sts;
  } ctl_word_u;

  // clamp to the signed sample range
  function automatic logic signed [DW-1:0] sat_dw(input int val);
    if (val > SMAX) begin
      return DW'(SMAX);
    end else if (val < SMIN) begin
      return DW'(SMIN);
    end
    return DW'(val);
  endfunction

endpackage

// File: source/gen_chan_if.sv
/*
 * generator channel link
 * configuration, command pulses and table writes from the register bank,
 * run state and burst status back from the channel
 */
interface gen_chan_if;

  // mode
  logic cfg_ben;
  logic cfg_inf;
  // pointer setup, fixed point
  logic [sig_gen_pkg::CW-1:0] cfg_siz;
  logic [sig_gen_pkg::CW-1:0] cfg_off;
  logic [sig_gen_pkg::CW-1:0] cfg_ste;
  // burst length in table periods
  logic [sig_gen_pkg::BNW-1:0] cfg_bnm;
  // linear transform and output enable
  logic signed [sig_gen_pkg::MW-1:0] cfg_mul;
  logic signed [sig_gen_pkg::DW-1:0] cfg_sum;
  logic cfg_ena;
  // single cycle commands
  logic cmd_rst;
  logic cmd_str;
  logic cmd_stp;
  logic cmd_trg;
  // table write port
  logic tbl_we;
  logic [sig_gen_pkg::TAW-1:0] tbl_addr;
  logic signed [sig_gen_pkg::DW-1:0] tbl_wdata;
  // channel status
  logic sts_run;
  logic evn_lst;
  logic [sig_gen_pkg::BNW-1:0] sts_bnm;

  modport regs (
    output cfg_ben, cfg_inf, cfg_siz, cfg_off, cfg_ste, cfg_bnm,
    output cfg_mul, cfg_sum, cfg_ena,
    output cmd_rst, cmd_str, cmd_stp, cmd_trg,
    output tbl_we, tbl_addr, tbl_wdata,
    input sts_run, evn_lst, sts_bnm
  );

  modport chan (
    input cfg_ben, cfg_inf, cfg_siz, cfg_off, cfg_ste, cfg_bnm,
    input cfg_mul, cfg_sum, cfg_ena,
    input cmd_rst, cmd_str, cmd_stp, cmd_trg,
    input tbl_we, tbl_addr, tbl_wdata,
    output sts_run, evn_lst, sts_bnm
  );

endinterface

// File: source/gen_regs.sv
/*
 * generator register bank
 * bus decode, per channel configuration, table writes, command pulses
 * with the external trigger merged in, and the burst end interrupt
 */
module gen_regs (
  input logic bus,
  input logic ctl_rst,
  input logic bus_wen,
  input logic bus_ren,
  input logic [sig_gen_pkg::AW-1:0] bus_addr,
  input logic [sig_gen_pkg::BW-1:0] bus_wdata,
  output logic [sig_gen_pkg::BW-1:0] bus_rdata,
  output logic bus_ack,
  input logic ext_trg,
  output logic irq,
  gen_chan_if.regs chn [sig_gen_pkg::NCH]
);

  // write data seen as a command word
  sig_gen_pkg::ctl_word_u wr_word;
  // per channel read word
  logic [sig_gen_pkg::BW-1:0] ch_rdata [sig_gen_pkg::NCH];
  // per channel interrupt status
  logic [sig_gen_pkg::NCH-1:0] irq_vec;

  assign wr_word = bus_wdata;

  ////////////////////
  // bus handshake
  ////////////////////

  // ack one cycle after any access
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      bus_ack <= 1'b0;
    end else begin
      bus_ack <= bus_wen | bus_ren;
    end
  end

  // tables are write only, reads there give zero
  always_ff @(posedge bus) begin
    if (bus_ren) begin
      if (bus_addr[sig_gen_pkg::ADR_TBL]) begin
        bus_rdata <= '0;
      end else begin
        bus_rdata <= ch_rdata[bus_addr[sig_gen_pkg::ADR_CH]];
      end
    end
  end

  ////////////////////
  // channel windows
  ////////////////////

  for (genvar ch = 0; ch < sig_gen_pkg::NCH; ch++) begin : g_ch
    logic ch_hit;
    logic reg_wr;
    logic tbl_wr;
    logic ctl_wr;
    logic irq_wr;
    logic trg_ena;
    logic sts_lst;
    logic irq_ena;
    logic irq_sts;
    sig_gen_pkg::ctl_word_u rd_word;
    logic [sig_gen_pkg::BW-1:0] rdata;

    // decode
    assign ch_hit = bus_addr[sig_gen_pkg::ADR_CH] == 1'(ch);
    assign reg_wr = bus_wen & ch_hit & ~bus_addr[sig_gen_pkg::ADR_TBL];
    assign tbl_wr = bus_wen & ch_hit & bus_addr[sig_gen_pkg::ADR_TBL];
    assign ctl_wr = reg_wr
                  & (bus_addr[sig_gen_pkg::ADR_TBL-1:0] == sig_gen_pkg::REG_CTL);
    assign irq_wr = reg_wr
                  & (bus_addr[sig_gen_pkg::ADR_TBL-1:0] == sig_gen_pkg::REG_IRQ);

    // configuration registers
    always_ff @(posedge bus) begin
      if (ctl_rst) begin
        chn[ch].cfg_ben <= 1'b0;
        chn[ch].cfg_inf <= 1'b0;
        chn[ch].cfg_ena <= 1'b0;
        chn[ch].cfg_siz <= '0;
        chn[ch].cfg_off <= '0;
        chn[ch].cfg_ste <= '0;
        chn[ch].cfg_bnm <= '0;
        chn[ch].cfg_mul <= '0;
        chn[ch].cfg_sum <= '0;
        trg_ena <= 1'b0;
        irq_ena <= 1'b0;
      end else if (reg_wr) begin
        case (bus_addr[sig_gen_pkg::ADR_TBL-1:0])
          // trigger enable rides along with every command word
          sig_gen_pkg::REG_CTL: trg_ena <= wr_word.cmd.trg_ena;
          sig_gen_pkg::REG_MODE: begin
            chn[ch].cfg_ben <= bus_wdata[sig_gen_pkg::MODE_BEN];
            chn[ch].cfg_inf <= bus_wdata[sig_gen_pkg::MODE_INF];
            chn[ch].cfg_ena <= bus_wdata[sig_gen_pkg::MODE_ENA];
          end
          sig_gen_pkg::REG_SIZ: chn[ch].cfg_siz <= bus_wdata[sig_gen_pkg::CW-1:0];
          sig_gen_pkg::REG_OFF: chn[ch].cfg_off <= bus_wdata[sig_gen_pkg::CW-1:0];
          sig_gen_pkg::REG_STE: chn[ch].cfg_ste <= bus_wdata[sig_gen_pkg::CW-1:0];
          sig_gen_pkg::REG_BNM: chn[ch].cfg_bnm <= bus_wdata[sig_gen_pkg::BNW-1:0];
          sig_gen_pkg::REG_MUL: chn[ch].cfg_mul <= bus_wdata[sig_gen_pkg::MW-1:0];
          sig_gen_pkg::REG_SUM: chn[ch].cfg_sum <= bus_wdata[sig_gen_pkg::DW-1:0];
          sig_gen_pkg::REG_IRQ: irq_ena <= bus_wdata[sig_gen_pkg::IRQ_ENA];
          default: ;
        endcase
      end
    end

    // command pulses, status bits, table write strobe
    always_ff @(posedge bus) begin
      if (ctl_rst) begin
        chn[ch].cmd_rst <= 1'b0;
        chn[ch].cmd_str <= 1'b0;
        chn[ch].cmd_stp <= 1'b0;
        chn[ch].cmd_trg <= 1'b0;
        chn[ch].tbl_we <= 1'b0;
        sts_lst <= 1'b0;
        irq_sts <= 1'b0;
      end else begin
        chn[ch].cmd_rst <= ctl_wr & wr_word.cmd.rst;
        chn[ch].cmd_str <= ctl_wr & wr_word.cmd.str;
        chn[ch].cmd_stp <= ctl_wr & wr_word.cmd.stp;
        // software trigger or enabled external trigger
        chn[ch].cmd_trg <= (ctl_wr & wr_word.cmd.swt) | (ext_trg & trg_ena);
        chn[ch].tbl_we <= tbl_wr;
        // last burst flag, cleared by a new start
        if (ctl_wr & (wr_word.cmd.str | wr_word.cmd.rst)) begin
          sts_lst <= 1'b0;
        end else if (chn[ch].evn_lst) begin
          sts_lst <= 1'b1;
        end
        // sticky interrupt, write 1 clears
        if (irq_wr & bus_wdata[sig_gen_pkg::IRQ_STS]) begin
          irq_sts <= 1'b0;
        end else if (chn[ch].evn_lst & irq_ena) begin
          irq_sts <= 1'b1;
        end
      end
    end

    // table address and data
    always_ff @(posedge bus) begin
      if (tbl_wr) begin
        chn[ch].tbl_addr <= bus_addr[sig_gen_pkg::TAW+1:2];
        chn[ch].tbl_wdata <= bus_wdata[sig_gen_pkg::DW-1:0];
      end
    end

    // read mux, control word reads back as status
    always_comb begin
      rd_word = '0;
      rd_word.sts.running = chn[ch].sts_run;
      rd_word.sts.last = sts_lst;
      rd_word.sts.trg_ena = trg_ena;
      rdata = '0;
      case (bus_addr[sig_gen_pkg::ADR_TBL-1:0])
        sig_gen_pkg::REG_CTL: rdata = rd_word;
        sig_gen_pkg::REG_MODE: begin
          rdata[sig_gen_pkg::MODE_BEN] = chn[ch].cfg_ben;
          rdata[sig_gen_pkg::MODE_INF] = chn[ch].cfg_inf;
          rdata[sig_gen_pkg::MODE_ENA] = chn[ch].cfg_ena;
        end
        sig_gen_pkg::REG_SIZ: rdata[sig_gen_pkg::CW-1:0] = chn[ch].cfg_siz;
        sig_gen_pkg::REG_OFF: rdata[sig_gen_pkg::CW-1:0] = chn[ch].cfg_off;
        sig_gen_pkg::REG_STE: rdata[sig_gen_pkg::CW-1:0] = chn[ch].cfg_ste;
        // upper half is the period count done so far
        sig_gen_pkg::REG_BNM: begin
          rdata[sig_gen_pkg::BNW-1:0] = chn[ch].cfg_bnm;
          rdata[2*sig_gen_pkg::BNW-1:sig_gen_pkg::BNW] = chn[ch].sts_bnm;
        end
        sig_gen_pkg::REG_MUL: rdata[sig_gen_pkg::MW-1:0] = chn[ch].cfg_mul;
        sig_gen_pkg::REG_SUM: rdata[sig_gen_pkg::DW-1:0] = chn[ch].cfg_sum;
        sig_gen_pkg::REG_IRQ: begin
          rdata[sig_gen_pkg::IRQ_ENA] = irq_ena;
          rdata[sig_gen_pkg::IRQ_STS] = irq_sts;
        end
        default: ;
      endcase
    end

    assign ch_rdata[ch] = rdata;
    assign irq_vec[ch] = irq_sts;
  end

  // interrupt line
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      irq <= 1'b0;
    end else begin
      irq <= |irq_vec;
    end
  end

endmodule

// File: source/gen_channel.sv
/*
 * generator channel
 * waveform table, armed/running control with a fixed point pointer
 * and burst counter, then gain, offset and saturation over 3 stages
 */
module gen_channel (
  input logic bus,
  input logic ctl_rst,
  gen_chan_if.chan cfg,
  output logic signed [sig_gen_pkg::DW-1:0] smp
);

  // waveform table
  logic signed [sig_gen_pkg::DW-1:0] mem [2**sig_gen_pkg::TAW];

  // control state
  logic arm;
  logic run;
  logic lst;
  logic [sig_gen_pkg::BNW-1:0] bnm;
  logic [sig_gen_pkg::BNW-1:0] bnm_nxt;
  logic start;
  logic done;

  // pointer, one carry bit on the add
  logic [sig_gen_pkg::CW-1:0] ptr;
  logic [sig_gen_pkg::CW:0] ptr_add;
  logic [sig_gen_pkg::CW:0] ptr_wrp;
  logic wrap;

  // pipeline
  logic [1:0] vld;
  logic signed [sig_gen_pkg::DW-1:0] rd_dat;
  logic signed [sig_gen_pkg::PW-1:0] mul;
  logic signed [sig_gen_pkg::PW:0] acc;

  ////////////////////
  // table memory
  ////////////////////

  always_ff @(posedge bus) begin
    if (cfg.tbl_we) begin
      mem[cfg.tbl_addr] <= cfg.tbl_wdata;
    end
  end

  ////////////////////
  // pointer and FSM
  ////////////////////

  // next pointer and modulo wrap
  assign ptr_add = {1'b0, ptr} + {1'b0, cfg.cfg_ste};
  assign wrap = ptr_add >= {1'b0, cfg.cfg_siz};
  assign ptr_wrp = ptr_add - {1'b0, cfg.cfg_siz};

  // trigger only counts while armed
  assign start = arm & cfg.cmd_trg;
  assign bnm_nxt = bnm + 1'b1;
  // finite burst ends on the wrap that reaches the period count
  assign done = run & wrap & cfg.cfg_ben & ~cfg.cfg_inf & (bnm_nxt == cfg.cfg_bnm);

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      arm <= 1'b0;
      run <= 1'b0;
      lst <= 1'b0;
      bnm <= '0;
    end else begin
      lst <= 1'b0;
      if (cfg.cmd_rst) begin
        arm <= 1'b0;
        run <= 1'b0;
        bnm <= '0;
      end else if (cfg.cmd_stp) begin
        arm <= 1'b0;
        run <= 1'b0;
      end else begin
        if (cfg.cmd_str) begin
          arm <= 1'b1;
        end
        if (start) begin
          // one shot, the trigger uses up the arm
          arm <= 1'b0;
          run <= 1'b1;
          bnm <= '0;
        end else if (run & wrap) begin
          bnm <= bnm_nxt;
          if (done) begin
            run <= 1'b0;
            lst <= 1'b1;
          end
        end
      end
    end
  end

  // phase load on start, step while running
  always_ff @(posedge bus) begin
    if (start) begin
      ptr <= cfg.cfg_off;
    end else if (run) begin
      if (wrap) begin
        ptr <= ptr_wrp[sig_gen_pkg::CW-1:0];
      end else begin
        ptr <= ptr_add[sig_gen_pkg::CW-1:0];
      end
    end
  end

  assign cfg.sts_run = run;
  assign cfg.evn_lst = lst;
  assign cfg.sts_bnm = bnm;

  ////////////////////
  // sample pipeline
  ////////////////////

  // valid follows run through read and multiply
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      vld <= '0;
    end else begin
      vld <= {vld[0], run};
    end
  end

  // stage 1 table read at the integer part, stage 2 gain
  always_ff @(posedge bus) begin
    rd_dat <= mem[ptr[sig_gen_pkg::CW-1:sig_gen_pkg::CWF]];
    mul <= rd_dat * cfg.cfg_mul;
  end

  // drop the gain fraction, add the offset
  assign acc = (mul >>> sig_gen_pkg::MSH) + cfg.cfg_sum;

  // stage 3 saturate, zero when idle or disabled
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      smp <= '0;
    end else if (vld[1] & cfg.cfg_ena) begin
      smp <= sig_gen_pkg::sat_dw(acc);
    end else begin
      smp <= '0;
    end
  end

endmodule

// File: source/dac_mixer.sv
/*
 * DAC output mixer
 * sums all channel samples and clamps to the signed DAC range,
 * one register stage
 */
module dac_mixer (
  input logic bus,
  input logic ctl_rst,
  input logic signed [sig_gen_pkg::DW-1:0] smp [sig_gen_pkg::NCH],
  output logic signed [sig_gen_pkg::DW-1:0] dac_dat
);

  // wide enough that the sum never wraps
  logic signed [sig_gen_pkg::XW-1:0] acc;

  ////////////////////
  // sum
  ////////////////////

  always_comb begin
    acc = '0;
    // samples are sign extended into the accumulator
    for (int i = 0; i < sig_gen_pkg::NCH; i++) begin
      acc = acc + smp[i];
    end
  end

  ////////////////////
  // clamp and register
  ////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      dac_dat <= '0;
    end else begin
      dac_dat <= sig_gen_pkg::sat_dw(acc);
    end
  end

endmodule

// File: source/sig_gen_top.sv
/*
 * two channel arbitrary waveform generator
 * register bank, generator channels and the DAC mixer
 */
module sig_gen_top (
  input logic bus,
  input logic ctl_rst,
  // CPU bus
  input logic bus_wen,
  input logic bus_ren,
  input logic [sig_gen_pkg::AW-1:0] bus_addr,
  input logic [sig_gen_pkg::BW-1:0] bus_wdata,
  output logic [sig_gen_pkg::BW-1:0] bus_rdata,
  output logic bus_ack,
  // trigger in, burst end interrupt out
  input logic ext_trg,
  output logic irq,
  // DAC word
  output logic signed [sig_gen_pkg::DW-1:0] dac_dat
);

  // one link per channel
  gen_chan_if chn_if [sig_gen_pkg::NCH] ();

  // channel samples into the mixer
  logic signed [sig_gen_pkg::DW-1:0] smp [sig_gen_pkg::NCH];

  gen_regs regs_i (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .bus_wen   (bus_wen),
    .bus_ren   (bus_ren),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .bus_ack   (bus_ack),
    .ext_trg   (ext_trg),
    .irq       (irq),
    .chn       (chn_if)
  );

  for (genvar ch = 0; ch < sig_gen_pkg::NCH; ch++) begin : g_chan
    gen_channel chan_i (
      .bus     (bus),
      .ctl_rst (ctl_rst),
      .cfg     (chn_if[ch]),
      .smp     (smp[ch])
    );
  end

  dac_mixer mix_i (
    .bus     (bus),
    .ctl_rst (ctl_rst),
    .smp     (smp),
    .dac_dat (dac_dat)
  );

endmodule

// File: sim/sig_gen_tb.sv
/*
 * waveform generator testbench
 * random bus stimulus against a cycle model of the channels, the mixer,
 * the interrupt and the register read data
 */
module sig_gen_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NCH = sig_gen_pkg::NCH;
  localparam int RUN_LEN = 300;
  localparam int N_CONT = 4;
  localparam int N_XFORM = 6;
  localparam int N_BURST = 4;
  localparam int N_BOTH = 3;
  // cycle budget per phase
  localparam int T_SETUP = 20;
  localparam int T_RUN = RUN_LEN + T_SETUP;
  localparam int T_BURST = T_SETUP + 4 * 33 + 16;
  localparam int T_TRIG = 2 * T_SETUP + 2 * RUN_LEN + 20;
  localparam int LIMIT = 2 * (NCH * 256 + NCH * 20 + (N_CONT + N_XFORM) * T_RUN
                            + N_BOTH * 2 * T_RUN + N_BURST * T_BURST + T_TRIG + 10);

  logic bus;
  logic ctl_rst;
  logic bus_wen;
  logic bus_ren;
  logic [sig_gen_pkg::AW-1:0] bus_addr;
  logic [sig_gen_pkg::BW-1:0] bus_wdata;
  logic [sig_gen_pkg::BW-1:0] bus_rdata;
  logic bus_ack;
  logic ext_trg;
  logic irq;
  logic signed [sig_gen_pkg::DW-1:0] dac_dat;

  // model configuration and state
  logic signed [13:0] m_tbl [NCH][256];
  logic [23:0] m_siz [NCH];
  logic [23:0] m_off [NCH];
  logic [23:0] m_ste [NCH];
  logic [23:0] m_ptr [NCH];
  logic [15:0] m_bnm [NCH];
  logic [15:0] m_cnt [NCH];
  logic signed [15:0] m_mul [NCH];
  logic signed [13:0] m_sum [NCH];
  logic [NCH-1:0] m_ben;
  logic [NCH-1:0] m_inf;
  logic [NCH-1:0] m_ena;
  logic [NCH-1:0] m_tena;
  logic [NCH-1:0] m_iena;
  logic [NCH-1:0] m_ists;
  logic [NCH-1:0] m_last;
  logic [NCH-1:0] m_arm;
  logic [NCH-1:0] m_run;
  logic [NCH-1:0] m_lst;
  // command pulses seen by the channels on the next edge
  logic [NCH-1:0] p_rst;
  logic [NCH-1:0] p_str;
  logic [NCH-1:0] p_stp;
  logic [NCH-1:0] p_trg;
  // mixed output delay line with dac_dat due at index 3
  logic signed [13:0] dpipe [4];
  logic m_ack;
  logic m_irq;
  logic [31:0] exp_rdata;
  logic mon_on = 1'b0;
  int cycles = 0;

  sig_gen_top dut_i (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .bus_wen   (bus_wen),
    .bus_ren   (bus_ren),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .bus_ack   (bus_ack),
    .ext_trg   (ext_trg),
    .irq       (irq),
    .dac_dat   (dac_dat)
  );

  initial begin
    bus = 1'b0;
    forever #10 bus = ~bus;
  end

  always @(posedge bus) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout: test sequence still running after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  ////////////////////
  // reference arithmetic
  ////////////////////

  function automatic int clamp_sample(input int v);
    if (v > 8191) begin
      return 8191;
    end else if (v < -8192) begin
      return -8192;
    end
    return v;
  endfunction

  // gain of 1.0 is 2^13 and the shift rounds down
  function automatic int scale_sample(input int s, input int g, input int o);
    int prod;
    prod = s * g;
    return clamp_sample((prod >>> 13) + o);
  endfunction

  function automatic logic [11:0] reg_addr(input int ch, input logic [9:0] off);
    return {ch[0], 1'b0, off};
  endfunction

  function automatic logic [11:0] tbl_addr(input int ch, input int idx);
    return {ch[0], 1'b1, idx[7:0], 2'b00};
  endfunction

  function automatic logic [31:0] cmd_word(input logic str, input logic swt, input logic stp,
                                           input logic rst, input logic tena);
    sig_gen_pkg::ctl_word_u w;
    w = '0;
    w.cmd.str = str;
    w.cmd.swt = swt;
    w.cmd.stp = stp;
    w.cmd.rst = rst;
    w.cmd.trg_ena = tena;
    return w;
  endfunction

  // read data from the model state before the edge
  function automatic logic [31:0] expected_read(input logic [11:0] addr);
    int c;
    sig_gen_pkg::ctl_word_u w;
    logic [31:0] r;
    c = addr[11];
    r = '0;
    w = '0;
    if (!addr[10]) begin
      case (addr[9:0])
        sig_gen_pkg::REG_CTL: begin
          w.sts.running = m_run[c];
          w.sts.last = m_last[c];
          w.sts.trg_ena = m_tena[c];
          r = w;
        end
        sig_gen_pkg::REG_MODE: r = {29'b0, m_ena[c], m_inf[c], m_ben[c]};
        sig_gen_pkg::REG_SIZ: r = {8'b0, m_siz[c]};
        sig_gen_pkg::REG_OFF: r = {8'b0, m_off[c]};
        sig_gen_pkg::REG_STE: r = {8'b0, m_ste[c]};
        sig_gen_pkg::REG_BNM: r = {m_cnt[c], m_bnm[c]};
        sig_gen_pkg::REG_MUL: r = {16'b0, m_mul[c]};
        sig_gen_pkg::REG_SUM: r = {18'b0, m_sum[c]};
        sig_gen_pkg::REG_IRQ: r = {30'b0, m_ists[c], m_iena[c]};
        default: r = '0;
      endcase
    end
    return r;
  endfunction

  ////////////////////
  // cycle model
  ////////////////////

  always @(posedge bus) begin : model
    int sum_all;
    int c;
    logic [24:0] add;
    logic wrap;
    logic start;
    logic ctl_wr;
    sig_gen_pkg::ctl_word_u w;
    if (ctl_rst) begin
      for (int i = 0; i < NCH; i++) begin
        m_siz[i] = '0;
        m_off[i] = '0;
        m_ste[i] = '0;
        m_ptr[i] = '0;
        m_bnm[i] = '0;
        m_cnt[i] = '0;
        m_mul[i] = '0;
        m_sum[i] = '0;
      end
      {m_ben, m_inf, m_ena, m_tena, m_iena, m_ists, m_last} = '0;
      {m_arm, m_run, m_lst, p_rst, p_str, p_stp, p_trg} = '0;
      for (int k = 0; k < 4; k++) begin
        dpipe[k] = '0;
      end
      m_ack = 1'b0;
      m_irq = 1'b0;
    end else begin
      w = bus_wdata;
      c = bus_addr[11];
      ctl_wr = bus_wen && !bus_addr[10] && bus_addr[9:0] == sig_gen_pkg::REG_CTL;
      if (bus_ren) begin
        exp_rdata = expected_read(bus_addr);
      end
      m_ack = bus_wen | bus_ren;
      m_irq = |m_ists;
      // samples at this edge's pointers reach dac_dat four edges on
      sum_all = 0;
      for (int ch = 0; ch < NCH; ch++) begin
        if (m_run[ch] && m_ena[ch]) begin
          sum_all += scale_sample(m_tbl[ch][m_ptr[ch][23:16]], m_mul[ch], m_sum[ch]);
        end
      end
      dpipe[3] = dpipe[2];
      dpipe[2] = dpipe[1];
      dpipe[1] = dpipe[0];
      dpipe[0] = 14'(clamp_sample(sum_all));
      for (int ch = 0; ch < NCH; ch++) begin
        // sticky status cleared by a write of 1
        if (bus_wen && !bus_addr[10] && c == ch && bus_addr[9:0] == sig_gen_pkg::REG_IRQ
            && bus_wdata[1]) begin
          m_ists[ch] = 1'b0;
        end else if (m_lst[ch] && m_iena[ch]) begin
          m_ists[ch] = 1'b1;
        end
        if (ctl_wr && c == ch && (w.cmd.str || w.cmd.rst)) begin
          m_last[ch] = 1'b0;
        end else if (m_lst[ch]) begin
          m_last[ch] = 1'b1;
        end
        // pointer step with modulo wrap
        add = {1'b0, m_ptr[ch]} + {1'b0, m_ste[ch]};
        wrap = add >= {1'b0, m_siz[ch]};
        start = m_arm[ch] && p_trg[ch];
        if (start) begin
          m_ptr[ch] = m_off[ch];
        end else if (m_run[ch]) begin
          m_ptr[ch] = wrap ? 24'(add - {1'b0, m_siz[ch]}) : add[23:0];
        end
        // armed and running states
        m_lst[ch] = 1'b0;
        if (p_rst[ch]) begin
          m_arm[ch] = 1'b0;
          m_run[ch] = 1'b0;
          m_cnt[ch] = '0;
        end else if (p_stp[ch]) begin
          m_arm[ch] = 1'b0;
          m_run[ch] = 1'b0;
        end else begin
          if (p_str[ch]) begin
            m_arm[ch] = 1'b1;
          end
          if (start) begin
            m_arm[ch] = 1'b0;
            m_run[ch] = 1'b1;
            m_cnt[ch] = '0;
          end else if (m_run[ch] && wrap) begin
            m_cnt[ch] = m_cnt[ch] + 1'b1;
            if (m_ben[ch] && !m_inf[ch] && m_cnt[ch] == m_bnm[ch]) begin
              m_run[ch] = 1'b0;
              m_lst[ch] = 1'b1;
            end
          end
        end
        p_rst[ch] = ctl_wr && c == ch && w.cmd.rst;
        p_str[ch] = ctl_wr && c == ch && w.cmd.str;
        p_stp[ch] = ctl_wr && c == ch && w.cmd.stp;
        p_trg[ch] = (ctl_wr && c == ch && w.cmd.swt) || (ext_trg && m_tena[ch]);
      end
      // register and table writes
      if (bus_wen && bus_addr[10]) begin
        m_tbl[c][bus_addr[9:2]] = bus_wdata[13:0];
      end else if (bus_wen) begin
        case (bus_addr[9:0])
          sig_gen_pkg::REG_CTL: m_tena[c] = w.cmd.trg_ena;
          sig_gen_pkg::REG_MODE: {m_ena[c], m_inf[c], m_ben[c]} = bus_wdata[2:0];
          sig_gen_pkg::REG_SIZ: m_siz[c] = bus_wdata[23:0];
          sig_gen_pkg::REG_OFF: m_off[c] = bus_wdata[23:0];
          sig_gen_pkg::REG_STE: m_ste[c] = bus_wdata[23:0];
          sig_gen_pkg::REG_BNM: m_bnm[c] = bus_wdata[15:0];
          sig_gen_pkg::REG_MUL: m_mul[c] = bus_wdata[15:0];
          sig_gen_pkg::REG_SUM: m_sum[c] = bus_wdata[13:0];
          sig_gen_pkg::REG_IRQ: m_iena[c] = bus_wdata[0];
          default: ;
        endcase
      end
    end
  end

  // outputs compared every cycle once out of reset
  always @(negedge bus) begin
    if (mon_on) begin
      check_eq("dac_dat", 32'(dac_dat), 32'(dpipe[3]));
      check_eq("irq", 32'(irq), 32'(m_irq));
      check_eq("bus_ack", 32'(bus_ack), 32'(m_ack));
    end
  end

  ////////////////////
  // bus tasks
  ////////////////////

  // all tasks start and end on a falling edge
  task automatic idle(input int n);
    repeat (n) @(negedge bus);
  endtask

  task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
    bus_addr = addr;
    bus_wdata = data;
    bus_wen = 1'b1;
    @(negedge bus);
    bus_wen = 1'b0;
  endtask

  task automatic bus_read(input logic [11:0] addr);
    bus_addr = addr;
    bus_ren = 1'b1;
    @(negedge bus);
    bus_ren = 1'b0;
    check_eq("bus_ack", 32'(bus_ack), 32'h1);
    check_eq("bus_rdata", bus_rdata, exp_rdata);
  endtask

  task automatic setup_channel(input int ch, input logic [2:0] mode, input logic [23:0] siz,
                               input logic [23:0] off, input logic [23:0] ste,
                               input logic [15:0] bnm, input logic [15:0] mul,
                               input logic [13:0] sum, input logic iena);
    bus_write(reg_addr(ch, sig_gen_pkg::REG_MODE), {29'b0, mode});
    bus_write(reg_addr(ch, sig_gen_pkg::REG_SIZ), {8'b0, siz});
    bus_write(reg_addr(ch, sig_gen_pkg::REG_OFF), {8'b0, off});
    bus_write(reg_addr(ch, sig_gen_pkg::REG_STE), {8'b0, ste});
    bus_write(reg_addr(ch, sig_gen_pkg::REG_BNM), {16'b0, bnm});
    bus_write(reg_addr(ch, sig_gen_pkg::REG_MUL), {16'b0, mul});
    bus_write(reg_addr(ch, sig_gen_pkg::REG_SUM), {18'b0, sum});
    bus_write(reg_addr(ch, sig_gen_pkg::REG_IRQ), {30'b0, 1'b1, iena});
  endtask

  // step no smaller than siz/div bounds the period length
  task automatic random_pointer(input int div, output logic [23:0] siz,
                                output logic [23:0] off, output logic [23:0] ste);
    siz = 24'($urandom_range(32'hffffff, 32'h100000));
    ste = 24'($urandom_range(32'(siz) - 1, 32'(siz) / div));
    off = 24'($urandom_range(32'(siz) - 1, 0));
  endtask

  // start, run, stop and let the pipeline drain
  task automatic run_channel(input int ch, input int len);
    bus_write(reg_addr(ch, sig_gen_pkg::REG_CTL), cmd_word(1, 0, 0, 0, 0));
    bus_write(reg_addr(ch, sig_gen_pkg::REG_CTL), cmd_word(0, 1, 0, 0, 0));
    idle(len);
    bus_write(reg_addr(ch, sig_gen_pkg::REG_CTL), cmd_word(0, 0, 1, 0, 0));
    idle(6);
    check_eq("dac_dat", 32'(dac_dat), 32'h0);
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin : stimulus
    logic [23:0] siz;
    logic [23:0] off;
    logic [23:0] ste;
    logic [15:0] mul;
    logic [13:0] sum;
    void'($urandom(32'hfe10_1d2c));
    ctl_rst = 1'b1;
    bus_wen = 1'b0;
    bus_ren = 1'b0;
    bus_addr = '0;
    bus_wdata = '0;
    ext_trg = 1'b0;
    // two rising edges in reset
    repeat (2) @(posedge bus);
    @(negedge bus);
    ctl_rst = 1'b0;
    mon_on = 1'b1;
    // table load with the extremes in entries 0 and 1
    for (int c = 0; c < NCH; c++) begin
      for (int i = 0; i < 256; i++) begin
        if (i < 2) begin
          bus_write(tbl_addr(c, i), (i == 0) ? 32'h1fff : 32'h2000);
        end else begin
          bus_write(tbl_addr(c, i), $urandom);
        end
      end
    end
    // register readback plus control word, unused slot and table reads
    for (int c = 0; c < NCH; c++) begin
      for (int r = 1; r <= 8; r++) begin
        bus_write(reg_addr(c, 10'(4 * r)), $urandom);
        bus_read(reg_addr(c, 10'(4 * r)));
      end
      bus_write(reg_addr(c, sig_gen_pkg::REG_CTL), cmd_word(0, 0, 0, 0, 1'($urandom)));
      bus_read(reg_addr(c, sig_gen_pkg::REG_CTL));
      bus_read(reg_addr(c, 10'h024));
      bus_read(tbl_addr(c, $urandom_range(255, 0)));
    end
    // continuous mode at unity gain
    for (int r = 0; r < N_CONT; r++) begin
      random_pointer(256, siz, off, ste);
      setup_channel(0, ($urandom % 2) ? 3'b111 : 3'b100, siz, off, ste, 16'h0, 16'h2000,
                    14'h0, 1'b0);
      run_channel(0, RUN_LEN);
    end
    // gain and offset with the extremes first and the last round disabled
    for (int r = 0; r < N_XFORM; r++) begin
      random_pointer(256, siz, off, ste);
      case (r % 3)
        0: begin
          mul = 16'h7fff;
          sum = 14'h1fff;
        end
        1: begin
          mul = 16'h8000;
          sum = 14'h2000;
        end
        default: begin
          mul = 16'($urandom);
          sum = 14'($urandom);
        end
      endcase
      setup_channel(r % NCH, (r == N_XFORM - 1) ? 3'b000 : 3'b100, siz, off, ste, 16'h0,
                    mul, sum, 1'b0);
      run_channel(r % NCH, RUN_LEN);
    end
    // finite bursts with the interrupt on
    for (int r = 0; r < N_BURST; r++) begin
      random_pointer(32, siz, off, ste);
      setup_channel(r % NCH, 3'b101, siz, off, ste, 16'($urandom_range(4, 1)), 16'h2000,
                    14'($urandom), 1'b1);
      bus_write(reg_addr(r % NCH, sig_gen_pkg::REG_CTL), cmd_word(1, 0, 0, 0, 0));
      bus_write(reg_addr(r % NCH, sig_gen_pkg::REG_CTL), cmd_word(0, 1, 0, 0, 0));
      while (irq !== 1'b1) begin
        @(negedge bus);
      end
      idle(6);
      check_eq("dac_dat", 32'(dac_dat), 32'h0);
      bus_read(reg_addr(r % NCH, sig_gen_pkg::REG_CTL));
      bus_read(reg_addr(r % NCH, sig_gen_pkg::REG_BNM));
      bus_read(reg_addr(r % NCH, sig_gen_pkg::REG_IRQ));
      bus_write(reg_addr(r % NCH, sig_gen_pkg::REG_IRQ), 32'h3);
      idle(2);
      check_eq("irq", 32'(irq), 32'h0);
    end
    // external trigger reaches only channel 0 and channel 1 starts by software
    for (int c = 0; c < NCH; c++) begin
      random_pointer(256, siz, off, ste);
      setup_channel(c, 3'b100, siz, off, ste, 16'h0, 16'($urandom), 14'($urandom), 1'b0);
    end
    bus_write(reg_addr(0, sig_gen_pkg::REG_CTL), cmd_word(1, 0, 0, 0, 1));
    bus_write(reg_addr(1, sig_gen_pkg::REG_CTL), cmd_word(1, 0, 0, 0, 0));
    idle($urandom_range(8, 1));
    ext_trg = 1'b1;
    @(negedge bus);
    ext_trg = 1'b0;
    idle(RUN_LEN);
    bus_read(reg_addr(0, sig_gen_pkg::REG_CTL));
    bus_read(reg_addr(1, sig_gen_pkg::REG_CTL));
    bus_write(reg_addr(1, sig_gen_pkg::REG_CTL), cmd_word(0, 1, 0, 0, 0));
    idle(RUN_LEN);
    bus_write(reg_addr(0, sig_gen_pkg::REG_CTL), cmd_word(0, 0, 1, 0, 0));
    bus_write(reg_addr(1, sig_gen_pkg::REG_CTL), cmd_word(0, 0, 0, 1, 0));
    idle(6);
    check_eq("dac_dat", 32'(dac_dat), 32'h0);
    bus_read(reg_addr(1, sig_gen_pkg::REG_BNM));
    // both channels into the mixer
    for (int r = 0; r < N_BOTH; r++) begin
      for (int c = 0; c < NCH; c++) begin
        random_pointer(256, siz, off, ste);
        setup_channel(c, 3'b100, siz, off, ste, 16'h0, 16'($urandom), 14'($urandom), 1'b0);
      end
      for (int c = 0; c < NCH; c++) begin
        bus_write(reg_addr(c, sig_gen_pkg::REG_CTL), cmd_word(1, 0, 0, 0, 0));
        bus_write(reg_addr(c, sig_gen_pkg::REG_CTL), cmd_word(0, 1, 0, 0, 0));
      end
      idle(RUN_LEN);
      for (int c = 0; c < NCH; c++) begin
        bus_write(reg_addr(c, sig_gen_pkg::REG_CTL), cmd_word(0, 0, 1, 0, 0));
      end
      idle(6);
      check_eq("dac_dat", 32'(dac_dat), 32'h0);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: verilog.f
source/sig_gen_pkg.sv
source/gen_chan_if.sv
source/gen_regs.sv
source/gen_channel.sv
source/dac_mixer.sv
source/sig_gen_top.sv
sim/sig_gen_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the waveform generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module sig_gen_tb -o sim_bin

# the simulator status is not trusted, the output is searched instead
out=$(./obj_dir/sim_bin 2>&1) || true
echo "$out"

if grep -q "PASS: all tests" <<< "$out"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
